//--- include/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// address split, tag | index | byte offset
`define CACHE_TAG_BITS 9
`define CACHE_INDEX_BITS 3
`define CACHE_OFFSET_BITS 4

// one entry per index
`define CACHE_SETS 8

// eight 16-bit words per line
`define CACHE_LINE_BITS 128

`endif

//--- list.f
+incdir+include
logic/lc3b_types.sv
logic/cache_ctrl_if.sv
logic/array.sv
logic/line_writer.sv
logic/cache_datapath.sv
logic/cache_control.sv
logic/cache.sv
test/cache_assert.sv
test/cache_tb.sv

//--- logic/array.sv
`include "cache_macros.svh"

module array #(
	parameter int width = 128
) (
	input logic clk,
	input logic rst_n,
	input logic write,
	input lc3b_types::lc3b_c_index index,
	input logic [width-1:0] datain,
	output logic [width-1:0] dataout
);

	logic [width-1:0] data [`CACHE_SETS];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `CACHE_SETS; i++)
				data[i] <= '0;
		end else if (write) begin
			data[index] <= datain;
		end
	end

	// read is combinational
	assign dataout = data[index];

endmodule : array

//--- logic/cache.sv
module cache (
	input logic clk,
	input logic rst_n,

	// cpu side
	input logic mem_read,
	input logic mem_write,
	input lc3b_types::lc3b_word mem_address,
	input lc3b_types::lc3b_word mem_wdata,
	input lc3b_types::lc3b_mem_wmask mem_byte_enable,
	output lc3b_types::lc3b_word mem_rdata,
	output logic mem_resp,

	// physical memory side
	output logic pmem_read,
	output logic pmem_write,
	output lc3b_types::lc3b_word pmem_address,
	output lc3b_types::lc3b_cache_line pmem_wdata,
	input lc3b_types::lc3b_cache_line pmem_rdata,
	input logic pmem_resp
);

	cache_ctrl_if ctl_bus ();

	cache_control control (
		.clk(clk),
		.rst_n(rst_n),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.pmem_resp(pmem_resp),
		.ctl(ctl_bus.ctrl),
		.mem_resp(mem_resp),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write)
	);

	cache_datapath datapath (
		.clk(clk),
		.rst_n(rst_n),
		.mem_address(mem_address),
		.mem_wdata(mem_wdata),
		.mem_byte_enable(mem_byte_enable),
		.pmem_rdata(pmem_rdata),
		.ctl(ctl_bus.dp),
		.mem_rdata(mem_rdata),
		.pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata)
	);

endmodule : cache

//--- logic/cache_control.sv
module cache_control (
	input logic clk,
	input logic rst_n,
	input logic mem_read,
	input logic mem_write,
	input logic pmem_resp,
	cache_ctrl_if.ctrl ctl,
	output logic mem_resp,
	output logic pmem_read,
	output logic pmem_write
);

	import lc3b_types::*;

	cache_state state;
	cache_state next_state;
	logic request;

	assign request = mem_read | mem_write;

	always_ff @(posedge clk) begin
		if (!rst_n)
			state <= s_idle;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		mem_resp = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		ctl.store_word = 1'b0;
		ctl.fill = 1'b0;
		ctl.lru_write = 1'b0;
		ctl.wb_addr_sel = 1'b0;

		unique case (state)
			s_idle: begin
				if (request) begin
					if (ctl.hit) begin
						// zero latency, arrays update at this edge
						mem_resp = 1'b1;
						ctl.lru_write = 1'b1;
						ctl.store_word = mem_write;
					end else if (ctl.victim_dirty) begin
						next_state = s_writeback;
					end else begin
						next_state = s_fetch;
					end
				end
			end

			s_writeback: begin
				pmem_write = 1'b1;
				ctl.wb_addr_sel = 1'b1;	// victim line address
				if (pmem_resp)
					next_state = s_fetch;
			end

			s_fetch: begin
				pmem_read = 1'b1;
				if (pmem_resp) begin
					ctl.fill = 1'b1;
					next_state = s_idle;	// request hits next cycle
				end
			end

			default: next_state = s_idle;
		endcase
	end

endmodule : cache_control

//--- logic/cache_ctrl_if.sv
interface cache_ctrl_if;

	// commands from the controller
	logic store_word;	// cpu write into hit way, marks dirty
	logic fill;	// pmem line into victim way
	logic lru_write;
	logic wb_addr_sel;	// victim tag on pmem_address

	// status from the datapath
	logic hit;
	logic victim_dirty;	// lru way valid and dirty

	modport ctrl (
		output store_word,
		output fill,
		output lru_write,
		output wb_addr_sel,
		input hit,
		input victim_dirty
	);

	modport dp (
		input store_word,
		input fill,
		input lru_write,
		input wb_addr_sel,
		output hit,
		output victim_dirty
	);

endinterface : cache_ctrl_if

//--- logic/cache_datapath.sv
module cache_datapath (
	input logic clk,
	input logic rst_n,
	input lc3b_types::lc3b_word mem_address,
	input lc3b_types::lc3b_word mem_wdata,
	input lc3b_types::lc3b_mem_wmask mem_byte_enable,
	input lc3b_types::lc3b_cache_line pmem_rdata,
	cache_ctrl_if.dp ctl,
	output lc3b_types::lc3b_word mem_rdata,
	output lc3b_types::lc3b_word pmem_address,
	output lc3b_types::lc3b_cache_line pmem_wdata
);

	import lc3b_types::*;

	lc3b_c_tag tag;
	lc3b_c_index index;
	lc3b_c_offset offset;

	// per way read outputs
	lc3b_c_tag tag_out [2];
	lc3b_cache_line data_out [2];
	logic valid_out [2];
	logic dirty_out [2];

	logic [1:0] way_hit;
	logic [1:0] way_victim;
	logic lru_out;
	logic sel_way;
	lc3b_cache_line sel_line;
	lc3b_cache_line merged_line;
	lc3b_cache_line data_in;

	assign {tag, index, offset} = mem_address;

	for (genvar w = 0; w < 2; w++) begin : g_way
		logic fill_here;
		logic store_here;

		assign fill_here = ctl.fill & way_victim[w];
		assign store_here = ctl.store_word & way_hit[w];
		assign way_hit[w] = valid_out[w] & (tag_out[w] == tag);

		array #(.width(1)) valid_arr (
			.clk(clk),
			.rst_n(rst_n),
			.write(fill_here),
			.index(index),
			.datain(1'b1),
			.dataout(valid_out[w])
		);

		// set by a cpu store, cleared by a fill
		array #(.width(1)) dirty_arr (
			.clk(clk),
			.rst_n(rst_n),
			.write(fill_here | store_here),
			.index(index),
			.datain(ctl.store_word),
			.dataout(dirty_out[w])
		);

		array #(.width($bits(lc3b_c_tag))) tag_arr (
			.clk(clk),
			.rst_n(rst_n),
			.write(fill_here),
			.index(index),
			.datain(tag),
			.dataout(tag_out[w])
		);

		array #(.width($bits(lc3b_cache_line))) data_arr (
			.clk(clk),
			.rst_n(rst_n),
			.write(fill_here | store_here),
			.index(index),
			.datain(data_in),
			.dataout(data_out[w])
		);
	end

	array #(.width(1)) lru_arr (
		.clk(clk),
		.rst_n(rst_n),
		.write(ctl.lru_write),
		.index(index),
		.datain(~sel_way),	// other way becomes next victim
		.dataout(lru_out)
	);

	line_writer writer (
		.line(sel_line),
		.cpu_data(mem_wdata),
		.byte_enable(mem_byte_enable),
		.offset(offset),
		.out(merged_line)
	);

	assign way_victim = lru_out ? 2'b10 : 2'b01;
	assign ctl.hit = |way_hit;
	assign ctl.victim_dirty = valid_out[lru_out] & dirty_out[lru_out];

	// hitting way, else the lru way
	assign sel_way = ctl.hit ? way_hit[1] : lru_out;
	assign sel_line = data_out[sel_way];

	assign data_in = ctl.fill ? pmem_rdata : merged_line;
	assign mem_rdata = sel_line[{offset[3:1], 4'd0} +: 16];
	assign pmem_wdata = sel_line;

	always_comb begin
		if (ctl.wb_addr_sel)
			pmem_address = {tag_out[lru_out], index, lc3b_c_offset'(0)};
		else
			pmem_address = {tag, index, lc3b_c_offset'(0)};
	end

endmodule : cache_datapath

//--- logic/lc3b_types.sv
`include "cache_macros.svh"

package lc3b_types;

	// address or data word
	typedef logic [15:0] lc3b_word;

	// address fields, addr[15:7] | addr[6:4] | addr[3:0]
	typedef logic [`CACHE_TAG_BITS-1:0] lc3b_c_tag;
	typedef logic [`CACHE_INDEX_BITS-1:0] lc3b_c_index;
	typedef logic [`CACHE_OFFSET_BITS-1:0] lc3b_c_offset;

	// bit 0 low byte, bit 1 high byte
	typedef logic [1:0] lc3b_mem_wmask;

	// word k sits at bits 16k+15:16k
	typedef logic [`CACHE_LINE_BITS-1:0] lc3b_cache_line;

	// miss handling states
	typedef enum logic [1:0] {
		s_idle,
		s_writeback,
		s_fetch
	} cache_state;

endpackage : lc3b_types

//--- logic/line_writer.sv
module line_writer (
	input lc3b_types::lc3b_cache_line line,
	input lc3b_types::lc3b_word cpu_data,
	input lc3b_types::lc3b_mem_wmask byte_enable,
	input lc3b_types::lc3b_c_offset offset,
	output lc3b_types::lc3b_cache_line out
);

	logic [6:0] lo_base;
	logic [6:0] hi_base;

	// bit position of the addressed word, offset[0] ignored
	assign lo_base = {offset[3:1], 4'd0};
	assign hi_base = {offset[3:1], 4'd8};

	always_comb begin
		out = line;
		if (byte_enable[0])
			out[lo_base +: 8] = cpu_data[7:0];
		if (byte_enable[1])
			out[hi_base +: 8] = cpu_data[15:8];	// high byte
	end

endmodule : line_writer

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module cache_tb -f list.f \
	&& ./obj_dir/Vcache_tb > sim.log 2>&1 \
	|| echo "Errors found" >> sim.log
cat sim.log
grep -q "Errors found" sim.log && echo "FAIL" && exit 1
echo "PASS"
exit 0

//--- test/cache_assert.sv
module cache_assert (
	input logic clk,
	input logic rst_n,
	input lc3b_types::cache_state state,
	input logic mem_resp,
	input logic pmem_read,
	input logic pmem_write,
	input logic pmem_resp,
	input logic fill
);

	import lc3b_types::*;

	one_pmem_request: assert property (@(posedge clk) disable iff (!rst_n)
		!(pmem_read && pmem_write))
		else $error("pmem_read and pmem_write high together");

	// hits answer only from idle
	resp_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
		mem_resp |-> state == s_idle)
		else $error("mem_resp high outside s_idle");

	fill_on_resp: assert property (@(posedge clk) disable iff (!rst_n)
		fill |-> (pmem_resp && state == s_fetch))
		else $error("fill without pmem_resp in s_fetch");

	read_held: assert property (@(posedge clk) disable iff (!rst_n)
		(pmem_read && !pmem_resp) |=> pmem_read)
		else $error("pmem_read dropped before pmem_resp");

	write_held: assert property (@(posedge clk) disable iff (!rst_n)
		(pmem_write && !pmem_resp) |=> pmem_write)
		else $error("pmem_write dropped before pmem_resp");

endmodule : cache_assert

bind cache_control cache_assert check_inst (
	.clk(clk),
	.rst_n(rst_n),
	.state(state),
	.mem_resp(mem_resp),
	.pmem_read(pmem_read),
	.pmem_write(pmem_write),
	.pmem_resp(pmem_resp),
	.fill(ctl.fill)
);

//--- test/cache_tb.sv
`include "cache_macros.svh"

module cache_tb;

	import lc3b_types::*;

	logic clk;
	logic rst_n;
	logic mem_read;
	logic mem_write;
	lc3b_word mem_address;
	lc3b_word mem_wdata;
	lc3b_mem_wmask mem_byte_enable;
	lc3b_word mem_rdata;
	logic mem_resp;
	logic pmem_read;
	logic pmem_write;
	lc3b_word pmem_address;
	lc3b_cache_line pmem_wdata;
	lc3b_cache_line pmem_rdata;
	logic pmem_resp;

	lc3b_cache_line mem_lines [4096];	// physical memory, one entry per line
	logic [7:0] shadow [65536];	// what the cpu should see

	// two-way reference model
	lc3b_c_tag model_tag [`CACHE_SETS][2];
	logic model_valid [`CACHE_SETS][2];
	logic model_dirty [`CACHE_SETS][2];
	logic model_lru [`CACHE_SETS];

	lc3b_c_tag tag_pool [4];
	int seed;

	cache cache_inst (
		.clk(clk),
		.rst_n(rst_n),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_address(mem_address),
		.mem_wdata(mem_wdata),
		.mem_byte_enable(mem_byte_enable),
		.mem_rdata(mem_rdata),
		.mem_resp(mem_resp),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata),
		.pmem_rdata(pmem_rdata),
		.pmem_resp(pmem_resp)
	);

	always #2 clk = ~clk;

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// every address bit feeds the byte value
	function automatic logic [7:0] pattern_byte(input lc3b_word a);
		return a[7:0] ^ a[15:8] ^ 8'h6b;
	endfunction

	function automatic lc3b_cache_line shadow_line(input lc3b_word base);
		lc3b_cache_line line;
		line = '0;
		for (int b = 15; b >= 0; b--)
			line = {line[119:0], shadow[base + 16'(b)]};	// byte 0 ends up lowest
		return line;
	endfunction

	task automatic stop_run();
		$display("Errors found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check(input string name, input logic [127:0] expected,
			input logic [127:0] actual);
		if (actual !== expected) begin
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
			stop_run();
		end
	endtask

	task automatic wait_pmem(input logic want_write, input string what);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (want_write ? !pmem_write : !pmem_read) begin
			if (mem_resp) begin
				$display("mem_resp rose before the %s request", what);
				stop_run();
			end
			if (want_write ? pmem_read : pmem_write) begin
				$display("wrong memory request while waiting for the %s", what);
				stop_run();
			end
			cycles++;
			if (cycles >= 50) begin
				$display("timeout: the %s request never arrived", what);
				stop_run();
			end
			@(negedge clk);
		end
	endtask

	task automatic wait_resp(input string what);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!mem_resp) begin
			if (pmem_read || pmem_write) begin
				$display("unexpected memory request while waiting for the %s", what);
				stop_run();
			end
			cycles++;
			if (cycles >= 50) begin
				$display("timeout: mem_resp never arrived for the %s", what);
				stop_run();
			end
			@(negedge clk);
		end
	endtask

	// called at the negedge where a pmem request was seen
	task automatic serve_memory(input logic is_write);
		int delay;
		logic [11:0] line_idx;
		delay = 1 + rand_below(4);
		line_idx = pmem_address[15:4];
		if (is_write)
			mem_lines[line_idx] = pmem_wdata;
		repeat (delay) @(posedge clk);
		#1;
		pmem_resp = 1'b1;
		if (!is_write)
			pmem_rdata = mem_lines[line_idx];
		@(posedge clk);
		#1;
		pmem_resp = 1'b0;
		pmem_rdata = '0;
	endtask

	task automatic do_request(input logic is_write, input lc3b_word addr,
			input lc3b_word data, input lc3b_mem_wmask be);
		lc3b_c_tag tag;
		lc3b_c_index idx;
		logic hit;
		logic hit_way;
		logic victim;
		lc3b_word victim_addr;
		lc3b_word line_addr;
		tag = addr[15:7];
		idx = addr[6:4];
		line_addr = {addr[15:4], 4'b0};
		hit = 1'b1;
		hit_way = 1'b0;
		if (model_valid[idx][1] && model_tag[idx][1] == tag)
			hit_way = 1'b1;
		else if (!(model_valid[idx][0] && model_tag[idx][0] == tag))
			hit = 1'b0;

		mem_read = !is_write;
		mem_write = is_write;
		mem_address = addr;
		mem_wdata = data;
		mem_byte_enable = be;

		if (!hit) begin
			victim = model_lru[idx];
			if (model_valid[idx][victim] && model_dirty[idx][victim]) begin
				victim_addr = {model_tag[idx][victim], idx, 4'b0};
				wait_pmem(1'b1, "dirty write-back");
				check("writeback address", 128'(victim_addr), 128'(pmem_address));
				check("writeback data", shadow_line(victim_addr), pmem_wdata);
				serve_memory(1'b1);
			end
			wait_pmem(1'b0, "line fetch");	// a clean victim must skip the write
			check("fetch address", 128'(line_addr), 128'(pmem_address));
			serve_memory(1'b0);
			model_tag[idx][victim] = tag;
			model_valid[idx][victim] = 1'b1;
			model_dirty[idx][victim] = 1'b0;
			hit_way = victim;
		end

		wait_resp(hit ? "hit response" : "miss response");
		if (!is_write) begin
			check("read data", 128'({shadow[addr + 16'd1], shadow[addr]}), 128'(mem_rdata));
		end else begin
			if (be[0])
				shadow[addr] = data[7:0];
			if (be[1])
				shadow[addr + 16'd1] = data[15:8];
			model_dirty[idx][hit_way] = 1'b1;
		end
		model_lru[idx] = ~hit_way;

		@(posedge clk);
		#1;
		mem_read = 1'b0;
		mem_write = 1'b0;
	endtask

	initial begin
		int n;
		lc3b_word addr;
		clk = 1'b0;
		rst_n = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_address = '0;
		mem_wdata = '0;
		mem_byte_enable = '0;
		pmem_rdata = '0;
		pmem_resp = 1'b0;
		seed = 82;
		tag_pool[0] = 9'h000;
		tag_pool[1] = 9'h0a5;
		tag_pool[2] = 9'h1f3;
		tag_pool[3] = 9'h14c;

		for (int a = 0; a < 65536; a++)
			shadow[16'(a)] = pattern_byte(16'(a));
		for (int l = 0; l < 4096; l++)
			mem_lines[12'(l)] = shadow_line({12'(l), 4'b0});
		for (int s = 0; s < `CACHE_SETS; s++) begin
			model_lru[3'(s)] = 1'b0;
			for (int w = 0; w < 2; w++) begin
				model_tag[3'(s)][1'(w)] = '0;
				model_valid[3'(s)][1'(w)] = 1'b0;
				model_dirty[3'(s)][1'(w)] = 1'b0;
			end
		end

		repeat (4) begin
			@(posedge clk);
			#1;
			check("reset outputs low", 128'(3'b000), 128'({mem_resp, pmem_read, pmem_write}));
		end
		rst_n = 1'b1;
		@(negedge clk);
		check("outputs after reset", 128'(3'b000), 128'({mem_resp, pmem_read, pmem_write}));
		@(posedge clk);
		#1;

		n = 0;
		while (n < 2000) begin
			addr = {tag_pool[2'(rand_below(4))], 3'(rand_below(8)), 3'(rand_below(8)), 1'b0};
			if (rand_below(2) == 1) begin
				do_request(1'b1, addr, 16'(rand_below(65536)), 2'(1 + rand_below(3)));
				do_request(1'b0, addr, 16'h0000, 2'b11);	// read back
				do_request(1'b0, addr ^ 16'h0002, 16'h0000, 2'b11);	// neighbour word
				n += 3;
			end else begin
				do_request(1'b0, addr, 16'h0000, 2'b11);
				n++;
			end
		end

		$display("No errors");
		$finish;
	end

endmodule : cache_tb
